/* hdl/tx_pkg.sv */
package tx_pkg;

    // UART bit timing
    localparam int CLKS_PER_BAUD = 16;
    localparam int BAUD_CNT_W    = $clog2(CLKS_PER_BAUD);

    // Packet geometry
    localparam int PACKET_BYTES = 4;
    localparam int PACKET_BITS  = PACKET_BYTES * 8;
    localparam int BYTE_CNT_W   = $clog2(PACKET_BYTES);
    localparam int BIT_CNT_W    = $clog2(PACKET_BITS + 1);

    // DAC side, offset binary
    localparam int DATA_WIDTH         = 12;
    localparam int SAMPLES_PER_SYMBOL = 8;
    localparam int SAMPLE_IDX_W       = $clog2(SAMPLES_PER_SYMBOL);
    localparam logic [DATA_WIDTH-1:0] DAC_MID = DATA_WIDTH'(2048);

    // 1800 * sin(22.5 + k*45 deg), rounded; one full period per symbol
    localparam int SINE_AMP [SAMPLES_PER_SYMBOL] = '{
        689, 1663, 1663, 689,
        -689, -1663, -1663, -689
    };

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    typedef struct packed {
        logic [7:0] data;
        logic       frame_err;
    } rx_byte_t;

    // First received byte sits in the top byte
    typedef struct packed {
        logic [PACKET_BITS-1:0] payload;
    } packet_t;

    typedef enum logic {
        MOD_IDLE,
        MOD_SYMBOL
    } mod_state_e;

endpackage

/* hdl/uart_byte_read.sv */
`timescale 1ns/10ps

module uart_byte_read (
    input  logic             clk,
    input  logic             rst,
    input  logic             rxd,
    output tx_pkg::rx_byte_t rx_byte,
    output logic             rx_strobe,
    output logic             framing_error
);

    import tx_pkg::*;

    // Bit 1 is the synchronised line, bit 2 its value one cycle earlier
    logic [2:0]            rxd_pipe;
    logic                  rxd_s;
    logic                  start_edge;

    uart_state_e           state;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]            bit_cnt;
    logic [7:0]            shift_reg;
    logic                  baud_half;
    logic                  baud_full;
    logic                  sample_bit;
    logic                  sample_stop;

    assign rxd_s       = rxd_pipe[1];
    assign start_edge  = rxd_pipe[2] & ~rxd_pipe[1];
    assign baud_half   = baud_cnt == BAUD_CNT_W'(CLKS_PER_BAUD / 2 - 1);
    assign baud_full   = baud_cnt == BAUD_CNT_W'(CLKS_PER_BAUD - 1);
    assign sample_bit  = (state == UART_DATA) && baud_full;
    assign sample_stop = (state == UART_STOP) && baud_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_pipe <= '1;
        end else begin
            rxd_pipe <= {rxd_pipe[1:0], rxd};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= UART_IDLE;
            baud_cnt      <= '0;
            bit_cnt       <= '0;
            rx_strobe     <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            rx_strobe     <= 1'b0;
            framing_error <= 1'b0;
            baud_cnt      <= baud_cnt + 1'b1;
            case (state)
                UART_IDLE: begin
                    baud_cnt <= '0;
                    // Falling edge only, so a held-low line is not a new start
                    if (start_edge) begin
                        baud_cnt <= BAUD_CNT_W'(1);
                        state    <= UART_START;
                    end
                end
                UART_START: begin
                    if (rxd_s) begin
                        // Glitch, back to idle
                        state <= UART_IDLE;
                    end else if (baud_half) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= UART_DATA;
                    end
                end
                UART_DATA: begin
                    if (baud_full) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (baud_full) begin
                        rx_strobe     <= rxd_s;
                        framing_error <= ~rxd_s;
                        state         <= UART_IDLE;
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (sample_bit) begin
            shift_reg <= {rxd_s, shift_reg[7:1]};
        end
        if (sample_stop) begin
            rx_byte.data      <= shift_reg;
            rx_byte.frame_err <= ~rxd_s;
        end
    end

endmodule

/* hdl/byte_packet_buffer.sv */
`timescale 1ns/10ps

module byte_packet_buffer (
    input  logic             clk,
    input  logic             rst,
    input  tx_pkg::rx_byte_t rx_byte,
    input  logic             rx_strobe,
    output tx_pkg::packet_t  packet,
    output logic             packet_pending,
    input  logic             packet_take
);

    import tx_pkg::*;

    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic                  last_byte;
    logic                  accept;

    // Good bytes only, and none while a packet is waiting
    assign accept    = rx_strobe & ~rx_byte.frame_err & ~packet_pending;
    assign last_byte = byte_cnt == BYTE_CNT_W'(PACKET_BYTES - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt       <= '0;
            packet_pending <= 1'b0;
        end else begin
            if (accept) begin
                if (last_byte) begin
                    byte_cnt       <= '0;
                    packet_pending <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
            if (packet_take) begin
                packet_pending <= 1'b0;
            end
        end
    end

    // Sending order: byte 0 goes to the top of the payload
    always_ff @(posedge clk) begin
        if (accept) begin
            packet.payload[(PACKET_BYTES - 1 - int'(byte_cnt)) * 8 +: 8] <= rx_byte.data;
        end
    end

endmodule

/* hdl/parallel_serial.sv */
`timescale 1ns/10ps

module parallel_serial (
    input  logic            clk,
    input  logic            rst,
    input  tx_pkg::packet_t packet,
    input  logic            packet_pending,
    output logic            packet_take,
    input  logic            ser_next,
    output logic            bit_out,
    output logic            bit_valid,
    output logic            done
);

    import tx_pkg::*;

    logic [PACKET_BITS-1:0] shift_reg;
    logic [BIT_CNT_W-1:0]   bits_left;
    logic                   advance;

    assign bit_valid   = bits_left != '0;
    assign bit_out     = shift_reg[PACKET_BITS-1];
    // Load only when the previous packet is fully out
    assign packet_take = packet_pending & ~bit_valid;
    assign advance     = ser_next & bit_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            bits_left <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            if (packet_take) begin
                bits_left <= BIT_CNT_W'(PACKET_BITS);
            end else if (advance) begin
                bits_left <= bits_left - 1'b1;
                if (bits_left == BIT_CNT_W'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

    // MSB first
    always_ff @(posedge clk) begin
        if (packet_take) begin
            shift_reg <= packet.payload;
        end else if (advance) begin
            shift_reg <= {shift_reg[PACKET_BITS-2:0], 1'b0};
        end
    end

endmodule

/* hdl/signal_modulator.sv */
`timescale 1ns/10ps

module signal_modulator (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bit_out,
    input  logic                          bit_valid,
    output logic                          ser_next,
    output logic [tx_pkg::DATA_WIDTH-1:0] dac,
    output logic                          tx_active
);

    import tx_pkg::*;

    mod_state_e              state;
    logic [SAMPLE_IDX_W-1:0] sample_idx;
    logic                    cur_bit;
    logic                    boundary;
    logic                    sym_bit;
    logic [DATA_WIDTH-1:0]   amp;
    logic [DATA_WIDTH-1:0]   next_sample;

    // sample_idx is the sample being computed; dac shows it on the next cycle.
    // Index stays at zero while idle, so idle and symbol boundary load alike.
    assign boundary = (state == MOD_IDLE) || (sample_idx == '0);

    // Asked one cycle early so the next bit is ready at the boundary
    assign ser_next = (state == MOD_SYMBOL) &&
                      (sample_idx == SAMPLE_IDX_W'(SAMPLES_PER_SYMBOL - 1));

    assign sym_bit     = boundary ? bit_out : cur_bit;
    assign amp         = DATA_WIDTH'(SINE_AMP[sample_idx]);
    // A zero bit flips the phase by 180 degrees
    assign next_sample = sym_bit ? DAC_MID + amp : DAC_MID - amp;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= MOD_IDLE;
            sample_idx <= '0;
            dac        <= DAC_MID;
            tx_active  <= 1'b0;
        end else if (boundary && !bit_valid) begin
            // Nothing left to send
            state      <= MOD_IDLE;
            sample_idx <= '0;
            dac        <= DAC_MID;
            tx_active  <= 1'b0;
        end else begin
            state      <= MOD_SYMBOL;
            sample_idx <= sample_idx + 1'b1;
            dac        <= next_sample;
            tx_active  <= 1'b1;
        end
    end

    // Bit held for the rest of the symbol
    always_ff @(posedge clk) begin
        if (boundary) begin
            cur_bit <= bit_out;
        end
    end

endmodule

/* hdl/transmitter.sv */
`timescale 1ns/10ps

module transmitter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          uart_rxd,
    output logic [tx_pkg::DATA_WIDTH-1:0] dac,
    output logic                          tx_active,
    output logic                          framing_error
);

    import tx_pkg::*;

    rx_byte_t rx_byte;
    logic     rx_strobe;
    packet_t  packet;
    logic     packet_pending;
    logic     packet_take;
    logic     bit_out;
    logic     bit_valid;
    logic     ser_next;
    logic     ser_done;

    // Byte receiver
    uart_byte_read u_uart_rx (
        .clk           (clk),
        .rst           (rst),
        .rxd           (uart_rxd),
        .rx_byte       (rx_byte),
        .rx_strobe     (rx_strobe),
        .framing_error (framing_error)
    );

    // Bytes to packet, in sending order
    byte_packet_buffer u_buffer (
        .clk            (clk),
        .rst            (rst),
        .rx_byte        (rx_byte),
        .rx_strobe      (rx_strobe),
        .packet         (packet),
        .packet_pending (packet_pending),
        .packet_take    (packet_take)
    );

    parallel_serial u_serial (
        .clk            (clk),
        .rst            (rst),
        .packet         (packet),
        .packet_pending (packet_pending),
        .packet_take    (packet_take),
        .ser_next       (ser_next),
        .bit_out        (bit_out),
        .bit_valid      (bit_valid),
        .done           (ser_done)
    );

    // Phase keyed sine onto the DAC bus
    signal_modulator u_modulator (
        .clk       (clk),
        .rst       (rst),
        .bit_out   (bit_out),
        .bit_valid (bit_valid),
        .ser_next  (ser_next),
        .dac       (dac),
        .tx_active (tx_active)
    );

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

/* tests/tx_checker.sv */
`timescale 1ns/10ps

module tx_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          rx_strobe,
    input logic                          framing_error,
    input logic                          ser_done,
    input logic                          tx_active,
    input logic [tx_pkg::DATA_WIDTH-1:0] dac
);

    import tx_pkg::*;

    int burst_len;
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // Cycles of tx_active seen so far in the current burst
    always @(posedge clk) begin
        if (rst || !tx_active) begin
            burst_len <= 0;
        end else begin
            burst_len <= burst_len + 1;
        end
    end

    strobe_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(rx_strobe && framing_error)
    ) else begin
        $error("rx_strobe and framing_error high in the same cycle");
        fail_count++;
    end

    burst_not_long: assert property (
        @(posedge clk) disable iff (rst) tx_active |-> burst_len < PACKET_BITS * SAMPLES_PER_SYMBOL
    ) else begin
        $error("tx_active high for more than one packet of samples");
        fail_count++;
    end

    burst_exact: assert property (
        @(posedge clk) disable iff (rst)
        $fell(tx_active) |-> burst_len == PACKET_BITS * SAMPLES_PER_SYMBOL
    ) else begin
        $error("burst ended after %0d cycles", burst_len);
        fail_count++;
    end

    // Serializer done lands on the last sample of a burst
    done_ends_burst: assert property (
        @(posedge clk) disable iff (rst) ser_done |=> $fell(tx_active)
    ) else begin
        $error("serializer done was not followed by the end of the burst");
        fail_count++;
    end

    idle_mid_scale: assert property (
        @(posedge clk) disable iff (rst) !tx_active |-> dac == DAC_MID
    ) else begin
        $error("dac off mid-scale while idle");
        fail_count++;
    end

endmodule

bind transmitter tx_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .rx_strobe     (rx_strobe),
    .framing_error (framing_error),
    .ser_done      (ser_done),
    .tx_active     (tx_active),
    .dac           (dac)
);

/* tests/tx_monitor.sv */
`timescale 1ns/10ps

module tx_monitor (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [tx_pkg::DATA_WIDTH-1:0]   dac,
    input  logic                            tx_active,
    input  logic                            framing_error,
    input  logic                            exp_valid,
    input  tx_pkg::packet_t                 exp_packet,
    input  logic [tx_pkg::PACKET_BITS*tx_pkg::SAMPLES_PER_SYMBOL-1:0]
                 [tx_pkg::DATA_WIDTH-1:0]   exp_burst,
    input  int                              exp_frame_errs,
    input  logic                            end_check,
    output int                              value_errors,
    output int                              other_errors
);

    import tx_pkg::*;

    localparam int BURST_LEN = PACKET_BITS * SAMPLES_PER_SYMBOL;

    logic [BURST_LEN-1:0][DATA_WIDTH-1:0] burst_q [$];
    packet_t                              packet_q [$];
    logic [BURST_LEN-1:0][DATA_WIDTH-1:0] cur_burst;
    packet_t                              cur_packet;
    logic                                 have_ref;
    int                                   idx;
    int                                   frame_errs_seen;

    initial begin
        value_errors    = 0;
        other_errors    = 0;
        idx             = 0;
        frame_errs_seen = 0;
        have_ref        = 1'b0;
    end

    always @(posedge clk) begin
        if (exp_valid) begin
            packet_q.push_back(exp_packet);
            burst_q.push_back(exp_burst);
        end
        if (rst) begin
            idx = 0;
        end else if (tx_active) begin
            // First sample of a burst picks the oldest expected packet
            if (idx == 0) begin
                have_ref = packet_q.size() != 0;
                if (have_ref) begin
                    cur_packet = packet_q.pop_front();
                    cur_burst  = burst_q.pop_front();
                end else begin
                    $display("Error at %0d ns: burst started with no packet expected", $time);
                    other_errors++;
                end
            end
            if (have_ref && dac !== cur_burst[idx]) begin
                $display("mismatch at %0d ns: packet %h bit %0d sample %0d, dac %0d, expected %0d",
                         $time, cur_packet.payload, idx / SAMPLES_PER_SYMBOL,
                         idx % SAMPLES_PER_SYMBOL, dac, cur_burst[idx]);
                value_errors++;
            end
            idx = (idx + 1) % BURST_LEN;
        end else begin
            if (idx != 0) begin
                $display("Error at %0d ns: burst stopped after %0d samples", $time, idx);
                other_errors++;
                idx = 0;
            end
            if (dac !== DAC_MID) begin
                $display("mismatch at %0d ns: idle dac %0d, expected %0d", $time, dac, DAC_MID);
                value_errors++;
            end
        end
        if (!rst && framing_error) begin
            frame_errs_seen++;
        end
        if (end_check) begin
            if (packet_q.size() != 0) begin
                $display("Error at %0d ns: %0d expected packets were never transmitted",
                         $time, packet_q.size());
                other_errors++;
            end
            if (idx != 0) begin
                $display("Error at %0d ns: a burst is still running at the end", $time);
                other_errors++;
            end
            if (frame_errs_seen != exp_frame_errs) begin
                $display("mismatch at %0d ns: %0d framing errors seen, expected %0d",
                         $time, frame_errs_seen, exp_frame_errs);
                value_errors++;
            end
        end
    end

endmodule

/* tests/tb_transmitter.sv */
`timescale 1ns/10ps

module tb_transmitter;

    import tx_pkg::*;

    localparam int BURST_LEN  = PACKET_BITS * SAMPLES_PER_SYMBOL;
    localparam int FRAME_CLKS = PACKET_BYTES * 10 * CLKS_PER_BAUD;
    // 14 packets of frame, burst and slack, with a factor of two
    localparam int TIMEOUT_CYCLES = 14 * (FRAME_CLKS + BURST_LEN + 200) * 2;

    logic                                 clk;
    logic                                 rst;
    logic                                 uart_rxd;
    logic [DATA_WIDTH-1:0]                dac;
    logic                                 tx_active;
    logic                                 framing_error;
    logic                                 exp_valid;
    packet_t                              exp_packet;
    logic [BURST_LEN-1:0][DATA_WIDTH-1:0] exp_burst;
    int                                   exp_frame_errs;
    logic                                 end_check;
    int                                   value_errors;
    int                                   other_errors;
    int                                   cycle_cnt;
    logic [31:0]                          lcg_state;

    tb_clock u_clock (.clk(clk));

    transmitter u_dut (
        .clk           (clk),
        .rst           (rst),
        .uart_rxd      (uart_rxd),
        .dac           (dac),
        .tx_active     (tx_active),
        .framing_error (framing_error)
    );

    tx_monitor u_monitor (
        .clk            (clk),
        .rst            (rst),
        .dac            (dac),
        .tx_active      (tx_active),
        .framing_error  (framing_error),
        .exp_valid      (exp_valid),
        .exp_packet     (exp_packet),
        .exp_burst      (exp_burst),
        .exp_frame_errs (exp_frame_errs),
        .end_check      (end_check),
        .value_errors   (value_errors),
        .other_errors   (other_errors)
    );

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic logic [PACKET_BITS-1:0] random_packet();
        logic [PACKET_BITS-1:0] payload;
        int                     i;
        payload = '0;
        for (i = 0; i < PACKET_BYTES; i++) begin
            payload = {payload[PACKET_BITS-9:0], lcg_byte()};
        end
        return payload;
    endfunction

    // BPSK reference: 1800 * sin(22.5 + 45k deg) around mid-scale, MSB first
    function automatic logic [BURST_LEN-1:0][DATA_WIDTH-1:0] expected_burst(
        input logic [PACKET_BITS-1:0] payload
    );
        logic [BURST_LEN-1:0][DATA_WIDTH-1:0] burst;
        real                                  v;
        int                                   amp;
        int                                   b;
        int                                   k;
        for (b = 0; b < PACKET_BITS; b++) begin
            for (k = 0; k < SAMPLES_PER_SYMBOL; k++) begin
                v = 1800.0 * $sin((22.5 + 45.0 * k) * 3.14159265358979 / 180.0);
                amp = (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
                if (payload[PACKET_BITS-1-b]) begin
                    burst[b * SAMPLES_PER_SYMBOL + k] = DATA_WIDTH'(2048 + amp);
                end else begin
                    burst[b * SAMPLES_PER_SYMBOL + k] = DATA_WIDTH'(2048 - amp);
                end
            end
        end
        return burst;
    endfunction

    // 8N1 frame, LSB first; a bad stop bit is followed by one idle bit
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        logic [9:0] frame;
        int         i;
        frame = {~bad_stop, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd <= frame[i];
            repeat (CLKS_PER_BAUD - 1) @(posedge clk);
        end
        if (bad_stop) begin
            @(posedge clk);
            uart_rxd <= 1'b1;
            repeat (CLKS_PER_BAUD - 1) @(posedge clk);
        end
    endtask

    task automatic send_packet(input logic [PACKET_BITS-1:0] payload);
        int i;
        for (i = PACKET_BYTES - 1; i >= 0; i--) begin
            send_byte(payload[i*8 +: 8], 1'b0);
        end
    endtask

    task automatic expect_packet(input logic [PACKET_BITS-1:0] payload);
        @(posedge clk);
        exp_packet.payload <= payload;
        exp_burst          <= expected_burst(payload);
        exp_valid          <= 1'b1;
        @(posedge clk);
        exp_valid <= 1'b0;
    endtask

    // Burst may already be running when this is called
    task automatic wait_burst_end();
        do @(negedge clk); while (!tx_active);
        do @(negedge clk); while (tx_active);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run timed out after %0d cycles", cycle_cnt);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [PACKET_BITS-1:0] payload;
        int                     n;
        int                     assert_fails;
        rst            = 1'b1;
        uart_rxd       = 1'b1;
        exp_valid      = 1'b0;
        exp_packet     = '0;
        exp_burst      = '0;
        exp_frame_errs = 0;
        end_check      = 1'b0;
        lcg_state      = 32'd82606;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (20) @(posedge clk);

        payload = 32'hA500FF3C;
        expect_packet(payload);
        send_packet(payload);
        wait_burst_end();

        for (n = 0; n < 7; n++) begin
            payload = random_packet();
            expect_packet(payload);
            send_packet(payload);
            wait_burst_end();
        end

        // Next frame arrives while the previous burst is on the bus
        for (n = 0; n < 3; n++) begin
            payload = random_packet();
            expect_packet(payload);
            send_packet(payload);
        end
        wait_burst_end();

        // Bad byte between the first and second good byte
        payload = random_packet();
        expect_packet(payload);
        send_byte(payload[31:24], 1'b0);
        send_byte(8'h5A, 1'b1);
        exp_frame_errs <= exp_frame_errs + 1;
        send_byte(payload[23:16], 1'b0);
        send_byte(payload[15:8], 1'b0);
        send_byte(payload[7:0], 1'b0);
        wait_burst_end();

        // Two and a half bytes, then reset
        send_byte(lcg_byte(), 1'b0);
        send_byte(lcg_byte(), 1'b0);
        @(posedge clk);
        uart_rxd <= 1'b0;
        repeat (3 * CLKS_PER_BAUD) @(posedge clk);
        uart_rxd <= 1'b1;
        rst      <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2 * CLKS_PER_BAUD) @(posedge clk);
        payload = random_packet();
        expect_packet(payload);
        send_packet(payload);
        wait_burst_end();

        repeat (20) @(posedge clk);
        end_check <= 1'b1;
        @(posedge clk);
        end_check <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert_fails = u_dut.u_checker.fail_count;
        $display("Errors: %0d mismatch, %0d other, %0d assertion",
                 value_errors, other_errors, assert_fails);
        if (value_errors + other_errors + assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/tx_pkg.sv
hdl/uart_byte_read.sv
hdl/byte_packet_buffer.sv
hdl/parallel_serial.sv
hdl/signal_modulator.sv
hdl/transmitter.sv
tests/tb_clock.sv
tests/tx_checker.sv
tests/tx_monitor.sv
tests/tb_transmitter.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_transmitter
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the simulation prints the pass line
run: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
